//--- common/gat_defs.svh
`ifndef GAT_DEFS_SVH
`define GAT_DEFS_SVH

// ==============================
// Layer sizes
// ==============================

// Rows of W, equal to the input feature count
`define GAT_NUM_FEATURE_IN  8
// Columns of W
`define GAT_NUM_FEATURE_OUT 4
// Source half followed by destination half
`define GAT_A_DEPTH         (2 * `GAT_NUM_FEATURE_OUT)
// W words then a words, 40 in total
`define GAT_WEIGHT_DEPTH    (`GAT_NUM_FEATURE_OUT * `GAT_NUM_FEATURE_IN + `GAT_A_DEPTH)

// ==============================
// Element widths
// ==============================

`define GAT_DATA_W          8
`define GAT_WH_W            20
`define GAT_COEF_W          32
`define GAT_COL_IDX_W       $clog2(`GAT_NUM_FEATURE_IN)
`define GAT_WEIGHT_ADDR_W   $clog2(`GAT_WEIGHT_DEPTH)

`endif

//--- common/gat_pkg.sv
`include "gat_defs.svh"

package gat_pkg;

  // ==============================
  // Element types
  // ==============================

  // Weight, attention and feature element
  typedef logic signed [`GAT_DATA_W-1:0] data_t;

  // One Wh component, sized so a full row cannot overflow
  typedef logic signed [`GAT_WH_W-1:0] wh_t;

  // Source or destination attention score
  typedef logic signed [`GAT_COEF_W-1:0] coef_t;

  // Input feature column, also the row index of W
  typedef logic [`GAT_COL_IDX_W-1:0] col_idx_t;

endpackage

//--- src/weight_bram.sv
`include "gat_defs.svh"

module weight_bram (
  input  logic                          clk,
  input  logic                          wr_en_i,
  input  logic [`GAT_WEIGHT_ADDR_W-1:0] wr_addr_i,
  input  gat_pkg::data_t                wr_data_i,
  input  logic [`GAT_WEIGHT_ADDR_W-1:0] rd_addr_i,
  output gat_pkg::data_t                rd_data_o
);

  import gat_pkg::*;

  // W column by column, then a
  data_t mem [`GAT_WEIGHT_DEPTH];

  // Load port from the outside
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // Registered read, data one cycle after the address
  always_ff @(posedge clk) begin
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

//--- scheduler/weight_scheduler.sv
`include "gat_defs.svh"

module weight_scheduler (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          w_vld_i,
  output logic                          w_rdy_o,
  input  gat_pkg::data_t                bram_dout_i,
  output logic [`GAT_WEIGHT_ADDR_W-1:0] bram_addr_o,
  output gat_pkg::data_t                wgt_o [`GAT_NUM_FEATURE_OUT][`GAT_NUM_FEATURE_IN],
  output gat_pkg::data_t                a_o [`GAT_A_DEPTH]
);

  import gat_pkg::*;

  localparam int ADDR_W  = `GAT_WEIGHT_ADDR_W;
  localparam int COL_W   = $clog2(`GAT_NUM_FEATURE_OUT);
  localparam int A_CNT_W = $clog2(`GAT_A_DEPTH) + 1;

  localparam logic [ADDR_W-1:0]  ADDR_LAST = ADDR_W'(`GAT_WEIGHT_DEPTH - 1);
  localparam col_idx_t           ROW_LAST  = col_idx_t'(`GAT_NUM_FEATURE_IN - 1);
  localparam logic [COL_W-1:0]   COL_LAST  = COL_W'(`GAT_NUM_FEATURE_OUT - 1);
  localparam logic [A_CNT_W-1:0] A_FULL    = A_CNT_W'(`GAT_A_DEPTH);

  logic [ADDR_W-1:0]  addr_q;
  logic               vld_q;
  col_idx_t           row_q;
  logic [COL_W-1:0]   col_q;
  logic               w_done_q;
  logic [A_CNT_W-1:0] a_idx_q;
  logic               w_rdy_q;
  logic               w_cap;
  logic               a_cap;
  data_t              wgt_q [`GAT_NUM_FEATURE_OUT][`GAT_NUM_FEATURE_IN];
  data_t              a_q [`GAT_A_DEPTH];

  // ==============================
  // Read address
  // ==============================

  // Stops at the last word, repeated reads there are ignored
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
      vld_q  <= 1'b0;
    end else begin
      vld_q <= w_vld_i;
      if (w_vld_i && (addr_q != ADDR_LAST)) begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  // ==============================
  // Slot counters
  // ==============================

  // Returning word goes to W first, then to a
  assign w_cap = vld_q && !w_done_q;
  assign a_cap = vld_q && w_done_q && (a_idx_q != A_FULL);

  // Row runs fastest to match the column-major layout
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_q    <= '0;
      col_q    <= '0;
      w_done_q <= 1'b0;
      a_idx_q  <= '0;
    end else begin
      if (w_cap) begin
        if (row_q == ROW_LAST) begin
          row_q <= '0;
          if (col_q == COL_LAST) begin
            col_q    <= '0;
            w_done_q <= 1'b1;
          end else begin
            col_q <= col_q + 1'b1;
          end
        end else begin
          row_q <= row_q + 1'b1;
        end
      end
      if (a_cap) begin
        a_idx_q <= a_idx_q + 1'b1;
      end
    end
  end

  // ==============================
  // Register arrays
  // ==============================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int c = 0; c < `GAT_NUM_FEATURE_OUT; c++) begin
        for (int r = 0; r < `GAT_NUM_FEATURE_IN; r++) begin
          wgt_q[c][r] <= '0;
        end
      end
      for (int j = 0; j < `GAT_A_DEPTH; j++) begin
        a_q[j] <= '0;
      end
    end else begin
      if (w_cap) begin
        wgt_q[col_q][row_q] <= bram_dout_i;
      end
      if (a_cap) begin
        a_q[a_idx_q[A_CNT_W-2:0]] <= bram_dout_i;
      end
    end
  end

  // Sticky until reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_rdy_q <= 1'b0;
    end else if (w_done_q && (a_idx_q == A_FULL)) begin
      w_rdy_q <= 1'b1;
    end
  end

  assign bram_addr_o = addr_q;
  assign w_rdy_o     = w_rdy_q;
  assign wgt_o       = wgt_q;
  assign a_o         = a_q;

endmodule

//--- src/wh_multiplier.sv
`include "gat_defs.svh"

module wh_multiplier (
  input  logic              clk,
  input  logic              rst_n,
  input  gat_pkg::data_t    wgt_i [`GAT_NUM_FEATURE_OUT][`GAT_NUM_FEATURE_IN],
  input  logic              h_vld_i,
  input  gat_pkg::data_t    h_val_i,
  input  gat_pkg::col_idx_t h_col_i,
  input  logic              h_last_i,
  output logic              wh_vld_o,
  output gat_pkg::wh_t      wh_o [`GAT_NUM_FEATURE_OUT]
);

  import gat_pkg::*;

  localparam int PROD_W = 2 * `GAT_DATA_W;

  logic signed [PROD_W-1:0] prod [`GAT_NUM_FEATURE_OUT];
  wh_t                      sum [`GAT_NUM_FEATURE_OUT];
  wh_t                      acc_q [`GAT_NUM_FEATURE_OUT];
  wh_t                      wh_q [`GAT_NUM_FEATURE_OUT];
  logic                     wh_vld_q;

  // ==============================
  // Sparse entry update
  // ==============================

  // One W row picked by the column index, all outputs in parallel
  always_comb begin
    for (int c = 0; c < `GAT_NUM_FEATURE_OUT; c++) begin
      prod[c] = h_val_i * wgt_i[c][h_col_i];
      sum[c]  = acc_q[c] + wh_t'(prod[c]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_vld_q <= 1'b0;
      for (int c = 0; c < `GAT_NUM_FEATURE_OUT; c++) begin
        acc_q[c] <= '0;
        wh_q[c]  <= '0;
      end
    end else begin
      wh_vld_q <= h_vld_i && h_last_i;
      if (h_vld_i) begin
        for (int c = 0; c < `GAT_NUM_FEATURE_OUT; c++) begin
          if (h_last_i) begin
            // Row done, next entry starts from zero
            wh_q[c]  <= sum[c];
            acc_q[c] <= '0;
          end else begin
            acc_q[c] <= sum[c];
          end
        end
      end
    end
  end

  assign wh_vld_o = wh_vld_q;
  assign wh_o     = wh_q;

endmodule

//--- src/attention_coef.sv
`include "gat_defs.svh"

module attention_coef (
  input  logic           clk,
  input  logic           rst_n,
  input  gat_pkg::data_t a_i [`GAT_A_DEPTH],
  input  logic           wh_vld_i,
  input  gat_pkg::wh_t   wh_i [`GAT_NUM_FEATURE_OUT],
  output logic           coef_vld_o,
  output gat_pkg::coef_t coef_src_o,
  output gat_pkg::coef_t coef_dst_o
);

  import gat_pkg::*;

  coef_t src_sum;
  coef_t dst_sum;
  coef_t src_q;
  coef_t dst_q;
  logic  coef_vld_q;

  // ==============================
  // Dot products
  // ==============================

  // Lower half of a for source, upper half for destination
  always_comb begin
    src_sum = '0;
    dst_sum = '0;
    for (int j = 0; j < `GAT_NUM_FEATURE_OUT; j++) begin
      src_sum = src_sum + coef_t'(a_i[j]) * coef_t'(wh_i[j]);
      dst_sum = dst_sum + coef_t'(a_i[j + `GAT_NUM_FEATURE_OUT]) * coef_t'(wh_i[j]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      coef_vld_q <= 1'b0;
    end else begin
      coef_vld_q <= wh_vld_i;
    end
  end

  // Scores only change with a new Wh
  always_ff @(posedge clk) begin
    if (wh_vld_i) begin
      src_q <= src_sum;
      dst_q <= dst_sum;
    end
  end

  assign coef_vld_o = coef_vld_q;
  assign coef_src_o = src_q;
  assign coef_dst_o = dst_q;

endmodule

//--- src/gat_conv2_top.sv
`include "gat_defs.svh"

module gat_conv2_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          wgt_wr_en_i,
  input  logic [`GAT_WEIGHT_ADDR_W-1:0] wgt_wr_addr_i,
  input  gat_pkg::data_t                wgt_wr_data_i,
  input  logic                          w_vld_i,
  output logic                          w_rdy_o,
  input  logic                          h_vld_i,
  input  gat_pkg::data_t                h_val_i,
  input  gat_pkg::col_idx_t             h_col_i,
  input  logic                          h_last_i,
  output logic                          wh_vld_o,
  output gat_pkg::wh_t                  wh_o [`GAT_NUM_FEATURE_OUT],
  output logic                          coef_vld_o,
  output gat_pkg::coef_t                coef_src_o,
  output gat_pkg::coef_t                coef_dst_o
);

  import gat_pkg::*;

  logic [`GAT_WEIGHT_ADDR_W-1:0] bram_addr;
  data_t                         bram_dout;
  data_t                         wgt [`GAT_NUM_FEATURE_OUT][`GAT_NUM_FEATURE_IN];
  data_t                         a [`GAT_A_DEPTH];

  // ==============================
  // Weight load path
  // ==============================

  weight_bram u_weight_bram (
    .clk       (clk),
    .wr_en_i   (wgt_wr_en_i),
    .wr_addr_i (wgt_wr_addr_i),
    .wr_data_i (wgt_wr_data_i),
    .rd_addr_i (bram_addr),
    .rd_data_o (bram_dout)
  );

  weight_scheduler u_weight_scheduler (
    .clk         (clk),
    .rst_n       (rst_n),
    .w_vld_i     (w_vld_i),
    .w_rdy_o     (w_rdy_o),
    .bram_dout_i (bram_dout),
    .bram_addr_o (bram_addr),
    .wgt_o       (wgt),
    .a_o         (a)
  );

  // ==============================
  // Row pipeline
  // ==============================

  wh_multiplier u_wh_multiplier (
    .clk      (clk),
    .rst_n    (rst_n),
    .wgt_i    (wgt),
    .h_vld_i  (h_vld_i),
    .h_val_i  (h_val_i),
    .h_col_i  (h_col_i),
    .h_last_i (h_last_i),
    .wh_vld_o (wh_vld_o),
    .wh_o     (wh_o)
  );

  // Scores one cycle behind Wh
  attention_coef u_attention_coef (
    .clk        (clk),
    .rst_n      (rst_n),
    .a_i        (a),
    .wh_vld_i   (wh_vld_o),
    .wh_i       (wh_o),
    .coef_vld_o (coef_vld_o),
    .coef_src_o (coef_src_o),
    .coef_dst_o (coef_dst_o)
  );

endmodule

//--- test/tb_clock.sv
module tb_clock (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 8;

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Release just after an edge so the DUT sees a clean first cycle
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

//--- test/gat_conv2_tb.sv
`include "gat_defs.svh"

module gat_conv2_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import gat_pkg::*;

  localparam int NF_IN         = `GAT_NUM_FEATURE_IN;
  localparam int NF_OUT        = `GAT_NUM_FEATURE_OUT;
  localparam int A_DEPTH       = `GAT_A_DEPTH;
  localparam int DEPTH         = `GAT_WEIGHT_DEPTH;
  localparam int ADDR_W        = `GAT_WEIGHT_ADDR_W;
  localparam int RDY_WAIT      = DEPTH + 4;
  localparam int NUM_RAND_ROWS = 24;
  localparam int MARGIN        = 40;

  logic              clk;
  logic              rst_n;
  logic              wgt_wr_en;
  logic [ADDR_W-1:0] wgt_wr_addr;
  data_t             wgt_wr_data;
  logic              w_vld;
  logic              w_rdy;
  logic              h_vld;
  data_t             h_val;
  col_idx_t          h_col;
  logic              h_last;
  logic              wh_vld;
  wh_t               wh [NF_OUT];
  logic              coef_vld;
  coef_t             coef_src;
  coef_t             coef_dst;

  int     seed;
  int     watchdog_cycles;
  bit     load_started;
  longint w_ref [NF_OUT][NF_IN];
  longint a_ref [A_DEPTH];
  // One element per row entry
  longint ent_val [$];
  int     ent_col [$];
  bit     ent_last [$];
  // Expected results with NF_OUT Wh words per row
  longint exp_wh [$];
  longint exp_src [$];
  longint exp_dst [$];

  tb_clock u_clock (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  gat_conv2_top uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .wgt_wr_en_i   (wgt_wr_en),
    .wgt_wr_addr_i (wgt_wr_addr),
    .wgt_wr_data_i (wgt_wr_data),
    .w_vld_i       (w_vld),
    .w_rdy_o       (w_rdy),
    .h_vld_i       (h_vld),
    .h_val_i       (h_val),
    .h_col_i       (h_col),
    .h_last_i      (h_last),
    .wh_vld_o      (wh_vld),
    .wh_o          (wh),
    .coef_vld_o    (coef_vld),
    .coef_src_o    (coef_src),
    .coef_dst_o    (coef_dst)
  );

  // ==============================
  // Helpers
  // ==============================

  task automatic fail_run(string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(string sig, longint want, longint got);
    fail_run($sformatf("MISMATCH at %0t: %s expected %0d, got %0d", $time, sig, want, got));
  endtask

  function automatic longint rand_data();
    int r;
    r = $random(seed);
    return longint'(data_t'(r));
  endfunction

  function automatic int rand_below(int n);
    int r;
    r = $random(seed);
    if (r < 0) begin
      r = -(r + 1);
    end
    return r % n;
  endfunction

  function automatic void add_entry(longint val, int col, bit last);
    ent_val.push_back(val);
    ent_col.push_back(col);
    ent_last.push_back(last);
  endfunction

  function automatic void pick_weights();
    for (int c = 0; c < NF_OUT; c++) begin
      for (int r = 0; r < NF_IN; r++) begin
        w_ref[c][r] = rand_data();
      end
      // Extreme corners used by the overflow rows
      w_ref[c][0]       = -128;
      w_ref[c][NF_IN-1] = 127;
    end
    for (int j = 0; j < A_DEPTH; j++) begin
      a_ref[j] = rand_data();
    end
    a_ref[0]      = -128;
    a_ref[NF_OUT] = 127;
  endfunction

  function automatic void build_rows();
    int len;
    // Largest product magnitude on every entry
    for (int k = 0; k < NF_IN; k++) begin
      add_entry(-128, 0, k == NF_IN - 1);
    end
    for (int k = 0; k < NF_IN; k++) begin
      add_entry((k % 2) ? 127 : -128, (k % 2) ? NF_IN - 1 : 0, k == NF_IN - 1);
    end
    // Same column three times
    add_entry(rand_data(), 3, 1'b0);
    add_entry(rand_data(), 3, 1'b0);
    add_entry(rand_data(), 3, 1'b1);
    // Single-entry rows back to back
    for (int k = 0; k < 4; k++) begin
      add_entry(rand_data(), rand_below(NF_IN), 1'b1);
    end
    for (int r = 0; r < NUM_RAND_ROWS; r++) begin
      len = 1 + rand_below(6);
      for (int k = 0; k < len; k++) begin
        add_entry(rand_data(), rand_below(NF_IN), k == len - 1);
      end
    end
  endfunction

  // ==============================
  // Stimulus
  // ==============================

  task automatic write_memory();
    for (int i = 0; i < DEPTH; i++) begin
      @(posedge clk);
      #1;
      wgt_wr_en   = 1'b1;
      wgt_wr_addr = ADDR_W'(i);
      if (i < NF_OUT * NF_IN) begin
        wgt_wr_data = data_t'(w_ref[i / NF_IN][i % NF_IN]);
      end else begin
        wgt_wr_data = data_t'(a_ref[i - NF_OUT * NF_IN]);
      end
    end
    @(posedge clk);
    #1;
    wgt_wr_en = 1'b0;
  endtask

  task automatic load_weights();
    int cycles;
    cycles = 0;
    @(posedge clk);
    #1;
    w_vld        = 1'b1;
    load_started = 1'b1;
    while (!w_rdy) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > RDY_WAIT) begin
        fail_run($sformatf("w_rdy_o did not rise within %0d cycles of w_vld_i", RDY_WAIT));
      end
    end
  endtask

  task automatic drive_rows();
    longint acc [NF_OUT];
    longint src;
    longint dst;
    for (int c = 0; c < NF_OUT; c++) begin
      acc[c] = 0;
    end
    for (int e = 0; e < ent_val.size(); e++) begin
      @(posedge clk);
      #1;
      h_vld  = 1'b1;
      h_val  = data_t'(ent_val[e]);
      h_col  = col_idx_t'(ent_col[e]);
      h_last = ent_last[e];
      for (int c = 0; c < NF_OUT; c++) begin
        acc[c] += ent_val[e] * w_ref[c][ent_col[e]];
      end
      if (ent_last[e]) begin
        src = 0;
        dst = 0;
        for (int c = 0; c < NF_OUT; c++) begin
          exp_wh.push_back(acc[c]);
          src += a_ref[c] * acc[c];
          dst += a_ref[c + NF_OUT] * acc[c];
          acc[c] = 0;
        end
        exp_src.push_back(src);
        exp_dst.push_back(dst);
      end
    end
    @(posedge clk);
    #1;
    h_vld  = 1'b0;
    h_last = 1'b0;
  endtask

  initial begin
    seed         = 60814;
    load_started = 1'b0;
    wgt_wr_en    = 1'b0;
    wgt_wr_addr  = '0;
    wgt_wr_data  = '0;
    w_vld        = 1'b0;
    h_vld        = 1'b0;
    h_val        = '0;
    h_col        = '0;
    h_last       = 1'b0;
    pick_weights();
    build_rows();
    @(posedge rst_n);
    #1;
    assert (!w_rdy)
      else report_mismatch("w_rdy_o", 64'sd0, longint'(w_rdy));
    assert (!wh_vld)
      else report_mismatch("wh_vld_o", 64'sd0, longint'(wh_vld));
    assert (!coef_vld)
      else report_mismatch("coef_vld_o", 64'sd0, longint'(coef_vld));
    write_memory();
    load_weights();
    drive_rows();
    // Scores trail the last entry by two cycles
    repeat (4) @(posedge clk);
    #1;
    if (exp_wh.size() != 0 || exp_src.size() != 0) begin
      fail_run($sformatf("%0d rows left unchecked at the end", exp_src.size()));
    end else begin
      $display("test passed");
      $finish;
    end
  end

  // Reset, weight writes, load, all entries, then some slack
  initial begin
    #1;
    watchdog_cycles = 8 + DEPTH + 2 + RDY_WAIT + ent_val.size() + MARGIN;
    #(watchdog_cycles * 10);
    fail_run("watchdog expired before the test finished");
  end

  // ==============================
  // Checks
  // ==============================

  assert property (@(posedge clk) disable iff (!rst_n) coef_vld |-> $past(wh_vld))
    else report_mismatch("coef_vld_o", 64'sd0, 64'sd1);

  assert property (@(posedge clk) disable iff (!rst_n) wh_vld |=> coef_vld)
    else report_mismatch("coef_vld_o", 64'sd1, 64'sd0);

  // Ready is sticky
  assert property (@(posedge clk) disable iff (!rst_n) w_rdy |=> w_rdy)
    else report_mismatch("w_rdy_o", 64'sd1, 64'sd0);

  always @(posedge clk) begin
    longint want;
    if (rst_n) begin
      if (!load_started) begin
        assert (!w_rdy) else report_mismatch("w_rdy_o", 64'sd0, longint'(w_rdy));
      end
      if (wh_vld) begin
        if (exp_wh.size() < NF_OUT) begin
          fail_run("wh_vld_o pulsed with no row pending");
        end else begin
          for (int c = 0; c < NF_OUT; c++) begin
            want = exp_wh.pop_front();
            assert (longint'(wh[c]) == want)
              else report_mismatch($sformatf("wh_o[%0d]", c), want, longint'(wh[c]));
          end
        end
      end
      if (coef_vld) begin
        if (exp_src.size() == 0) begin
          fail_run("coef_vld_o pulsed with no scores pending");
        end else begin
          want = exp_src.pop_front();
          assert (longint'(coef_src) == want)
            else report_mismatch("coef_src_o", want, longint'(coef_src));
          want = exp_dst.pop_front();
          assert (longint'(coef_dst) == want)
            else report_mismatch("coef_dst_o", want, longint'(coef_dst));
        end
      end
    end
  end

endmodule

//--- build.f
+incdir+common
common/gat_pkg.sv
src/weight_bram.sv
scheduler/weight_scheduler.sv
src/wh_multiplier.sv
src/attention_coef.sv
src/gat_conv2_top.sv
test/tb_clock.sv
test/gat_conv2_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the GAT conv2 testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module gat_conv2_tb \
  -f build.f \
  -o sim_gat_conv2

# A $fatal in the testbench gives a nonzero exit status
./obj_dir/sim_gat_conv2
